// ==== cga_dcd_pkg.sv ====
// Microword field types, command codes and IDB source codes for the decoder
`default_nettype none

package cga_dcd_pkg;

  // Microword fields
  typedef logic [4:0] comm_t;  // Command field CSCOMM
  typedef logic [1:0] mis_t;   // Miscellaneous qualifier CSMIS
  typedef logic [4:0] idbs_t;  // IDB source select CSIDBS

  // Command codes, octal as in the microcode listing
  localparam comm_t CMD_LDPIL  = 5'o01;  // Load PIL
  localparam comm_t CMD_LDGPR  = 5'o02;  // Load GPR
  localparam comm_t CMD_WRTRF  = 5'o03;  // Write register file
  localparam comm_t CMD_CLIRQ  = 5'o04;  // Clear interrupt request
  localparam comm_t CMD_EPIC   = 5'o11;  // Enable interrupt controller
  localparam comm_t CMD_DSTOP  = 5'o14;  // Stop
  localparam comm_t CMD_CLFF   = 5'o16;  // Clear flip-flop
  localparam comm_t CMD_LDLC   = 5'o17;  // Load LC

  // Conditional commands, qualified by the mis field
  localparam comm_t CMD_COND22 = 5'o22;
  localparam comm_t CMD_COND23 = 5'o23;
  localparam comm_t CMD_COND24 = 5'o24;
  localparam comm_t CMD_COND25 = 5'o25;

  localparam comm_t CMD_LWCA   = 5'o36;  // Load WCA

  // IDB bus sources
  localparam idbs_t SRC_REG    = 5'o05;  // Register file
  localparam idbs_t SRC_PICS   = 5'o15;
  localparam idbs_t SRC_PGS    = 5'o23;
  localparam idbs_t SRC_PCR    = 5'o25;
  localparam idbs_t SRC_PICV   = 5'o31;

endpackage

`default_nettype wire

// ==== cga_dcd_comm_decode.sv ====
// Command register, load-LC and load-PIL decodes and the two-flop stop strobe
`timescale 1ns/1ps
`default_nettype none

module cga_dcd_comm_decode (
  input  logic               s_mclk,
  input  logic               s_mr_n,
  input  cga_dcd_pkg::comm_t cscomm,
  input  cga_dcd_pkg::mis_t  csmis,
  input  logic               lcs_n,
  output cga_dcd_pkg::comm_t comm,
  output cga_dcd_pkg::mis_t  mis,
  output logic               ldlc_n,
  output logic               ldpil_n,
  output logic               dstop_n
);
  import cga_dcd_pkg::*;

  logic stop_dec;  // Stop decoded from the command register
  logic istop_n;   // First stage of the stop delay

  // Command register, loads every cycle
  // Bit 4 is dropped while LCS is active, so no 2x/3x code survives
  always_ff @(posedge s_mclk or negedge s_mr_n) begin
    if (!s_mr_n) begin
      comm <= '0;
      mis  <= '0;
    end else begin
      comm <= {cscomm[4] & lcs_n, cscomm[3:0]};
      mis  <= csmis;
    end
  end

  // Register decodes qualified by the live load-control line
  assign ldlc_n  = ~(lcs_n && (comm == CMD_LDLC));
  assign ldpil_n = ~(lcs_n && (comm == CMD_LDPIL));

  assign stop_dec = lcs_n && (comm == CMD_DSTOP);

  // Stop goes through two flops before it leaves the block
  always_ff @(posedge s_mclk or negedge s_mr_n) begin
    if (!s_mr_n) begin
      istop_n <= 1'b1;
      dstop_n <= 1'b1;
    end else begin
      istop_n <= ~stop_dec;
      dstop_n <= istop_n;
    end
  end

  // A stop longer than one cycle needs the stop command in two successive words
  dstop_single_a : assert property (
    @(posedge s_mclk) disable iff (!s_mr_n)
    (!dstop_n && !$past(dstop_n)) |->
      ($past(comm, 2) == CMD_DSTOP && $past(comm, 3) == CMD_DSTOP)
  ) else $error("dstop_n low for two cycles without two stop commands");

endmodule

`default_nettype wire

// ==== cga_dcd_branch.sv ====
// Conditional-branch and indirect decode from the command register and the flags
`timescale 1ns/1ps
`default_nettype none

module cga_dcd_branch (
  input  cga_dcd_pkg::comm_t comm,
  input  cga_dcd_pkg::mis_t  mis,
  input  logic               cry,
  input  logic               f15,
  input  logic               sgr,
  input  logic               zf,
  input  logic               wp_n,
  output logic               cbrk_n,
  output logic               ind_n
);
  import cga_dcd_pkg::*;

  logic       en_lo;   // Commands 22 and 23
  logic       en_hi;   // Commands 24 and 25
  logic [2:0] sel;     // comm bit 0 over mis
  logic [7:0] dec_lo;  // 22.0 to 22.3 then 23.0 to 23.3
  logic [7:0] dec_hi;  // 24.0 to 24.3 then 25.0 to 25.3
  logic       brk_22;
  logic       brk_23;
  logic       brk_24;
  logic       brk_25;

  assign en_lo = (comm == CMD_COND22) || (comm == CMD_COND23);
  assign en_hi = (comm == CMD_COND24) || (comm == CMD_COND25);
  assign sel   = {comm[0], mis};

  // Two one-of-eight decoders sharing the select
  assign dec_lo = en_lo ? (8'b0000_0001 << sel) : 8'b0000_0000;
  assign dec_hi = en_hi ? (8'b0000_0001 << sel) : 8'b0000_0000;

  // 24.n tests sign then carry in both polarities
  assign brk_24 = (dec_hi[0] & ~sgr) | (dec_hi[1] & sgr) |
                  (dec_hi[2] & ~cry) | (dec_hi[3] & cry);

  // 25.n and 23.n both test F15 then zero
  assign brk_25 = (dec_hi[4] & ~f15) | (dec_hi[5] & f15) |
                  (dec_hi[6] & ~zf)  | (dec_hi[7] & zf);
  assign brk_23 = (dec_lo[4] & ~f15) | (dec_lo[5] & f15) |
                  (dec_lo[6] & ~zf)  | (dec_lo[7] & zf);

  assign brk_22 = dec_lo[3] & ~wp_n;  // 22.3 tests write protect

  assign cbrk_n = ~(brk_22 | brk_23 | brk_24 | brk_25);

  // Indirect addressing on 22.0 and 22.1
  assign ind_n = ~(dec_lo[0] | dec_lo[1]);

  dec_onehot_a : assert final ($isunknown({comm, mis}) || $onehot0({dec_hi, dec_lo}))
    else $error("more than one branch decoder line active");

endmodule

`default_nettype wire

// ==== cga_dcd_cs_strobes.sv ====
// Registered strobes from the live command field, fetch capture and memory request
`timescale 1ns/1ps
`default_nettype none

module cga_dcd_cs_strobes (
  input  logic               s_mclk,
  input  logic               s_mr_n,
  input  cga_dcd_pkg::comm_t cscomm,
  input  cga_dcd_pkg::mis_t  csmis,
  input  logic               lcs_n,
  input  logic               brk_n,
  output logic               write_n,
  output logic               clff_n,
  output logic               clirq_n,
  output logic               epic,
  output logic               lwca_n,
  output logic               ldgpr_n,
  output logic               wrtrf,
  output logic               wrtrf_q,
  output logic               fetch_n,
  output logic               cfetch,
  output logic               csmreq
);
  import cga_dcd_pkg::*;

  logic dec_write;
  logic dec_clff;
  logic dec_clirq;
  logic dec_epic;
  logic dec_lwca;
  logic dec_ldgpr;
  logic dec_wrtrf;
  logic dec_fetch;
  logic grp_2x;    // Codes 20 to 27
  logic grp_3x;    // Codes 30 to 37
  logic clirq_q;

  assign grp_2x = cscomm[4:3] == 2'b10;
  assign grp_3x = cscomm[4:3] == 2'b11;

  // Live microword decodes, all blanked while LCS is active
  assign dec_write = lcs_n && (cscomm == 5'o32 || cscomm == 5'o33 || cscomm == 5'o35);
  assign dec_clff  = lcs_n && (cscomm == CMD_CLFF);
  assign dec_clirq = lcs_n && (cscomm == CMD_CLIRQ);
  assign dec_epic  = lcs_n && (cscomm == CMD_EPIC);
  assign dec_lwca  = lcs_n && (cscomm == CMD_LWCA) && (csmis == 2'd0);
  assign dec_ldgpr = lcs_n && ((cscomm == CMD_LDGPR) ||
                               (cscomm == CMD_COND22 && csmis == 2'd2));
  assign dec_wrtrf = lcs_n && (cscomm == CMD_WRTRF);

  // 24-27, 23 and 27, or 22 and 26 with mis 3
  assign dec_fetch = lcs_n && grp_2x &&
                     (cscomm[2] || (cscomm[1] && (cscomm[0] || csmis == 2'd3)));

  // Memory request goes straight out, no register
  assign csmreq = lcs_n && (
                    (cscomm == CMD_COND22 && csmis != 2'd2) ||
                    (grp_2x && (cscomm[2] || (cscomm[1] && cscomm[0]))) ||
                    (grp_3x && (!cscomm[2] || !cscomm[1])));

  always_ff @(posedge s_mclk or negedge s_mr_n) begin
    if (!s_mr_n) begin
      write_n <= 1'b1;
      clff_n  <= 1'b1;
      clirq_q <= 1'b0;
      epic    <= 1'b0;
      lwca_n  <= 1'b1;
      ldgpr_n <= 1'b1;
      wrtrf_q <= 1'b0;
      fetch_n <= 1'b1;
    end else begin
      write_n <= ~dec_write;
      clff_n  <= ~dec_clff;
      clirq_q <= dec_clirq;
      epic    <= dec_epic;
      lwca_n  <= ~dec_lwca;
      ldgpr_n <= ~dec_ldgpr;
      wrtrf_q <= dec_wrtrf;
      fetch_n <= ~dec_fetch;
    end
  end

  assign wrtrf = wrtrf_q;  // Same flop feeds the ERF merge

  // Interrupt request is also cleared for the whole master reset
  assign clirq_n = ~(clirq_q | ~s_mr_n);

  // Break freezes a copy of the fetch state
  always_ff @(posedge s_mclk or negedge s_mr_n) begin
    if (!s_mr_n) begin
      cfetch <= 1'b0;
    end else if (!brk_n) begin
      cfetch <= ~fetch_n;
    end
  end

  csmreq_known_a : assert property (
    @(posedge s_mclk) disable iff (!s_mr_n) !$isunknown(csmreq)
  ) else $error("csmreq unknown");

endmodule

`default_nettype wire

// ==== cga_dcd_idb_enables.sv ====
// Registered IDB source enables with the register-file write merged into ERF
`timescale 1ns/1ps
`default_nettype none

module cga_dcd_idb_enables (
  input  logic               s_mclk,
  input  logic               s_mr_n,
  input  cga_dcd_pkg::idbs_t csidbs,
  input  logic               lcs_n,
  input  logic               wrtrf_q,
  output logic               epgs_n,
  output logic               epcr_n,
  output logic               epicv_n,
  output logic               epics_n,
  output logic               erf_n
);
  import cga_dcd_pkg::*;

  logic dec_erf;

  // Register file drives IDB as a source, or one cycle after a register file write
  assign dec_erf = (lcs_n && csidbs == SRC_REG) || wrtrf_q;

  always_ff @(posedge s_mclk or negedge s_mr_n) begin
    if (!s_mr_n) begin
      epgs_n  <= 1'b1;
      epcr_n  <= 1'b1;
      epicv_n <= 1'b1;
      epics_n <= 1'b1;
      erf_n   <= 1'b1;
    end else begin
      epgs_n  <= ~(lcs_n && csidbs == SRC_PGS);
      epcr_n  <= ~(lcs_n && csidbs == SRC_PCR);
      epicv_n <= ~(lcs_n && csidbs == SRC_PICV);
      epics_n <= ~(lcs_n && csidbs == SRC_PICS);
      erf_n   <= ~dec_erf;
    end
  end

  // Only one of these may drive the IDB in any cycle
  idb_single_src_a : assert property (
    @(posedge s_mclk) disable iff (!s_mr_n)
    $onehot0(~{epgs_n, epcr_n, epicv_n, epics_n})
  ) else $error("more than one IDB source enabled");

endmodule

`default_nettype wire

// ==== cga_dcd.sv ====
// Decoder top level wiring the command register, branch, strobe and IDB decoders
`timescale 1ns/1ps
`default_nettype none

module cga_dcd (
  input  logic               s_mclk,
  input  logic               s_mr_n,
  input  cga_dcd_pkg::comm_t cscomm,
  input  cga_dcd_pkg::mis_t  csmis,
  input  cga_dcd_pkg::idbs_t csidbs,
  input  logic               lcs_n,
  input  logic               brk_n,
  input  logic               cry,
  input  logic               f15,
  input  logic               sgr,
  input  logic               zf,
  input  logic               wp_n,
  output logic               cbrk_n,
  output logic               cfetch,
  output logic               clff_n,
  output logic               clirq_n,
  output logic               csmreq,
  output logic               dstop_n,
  output logic               epcr_n,
  output logic               epgs_n,
  output logic               epic,
  output logic               epics_n,
  output logic               epicv_n,
  output logic               erf_n,
  output logic               fetch_n,
  output logic               ind_n,
  output logic               ldgpr_n,
  output logic               ldlc_n,
  output logic               ldpil_n,
  output logic               lwca_n,
  output logic               write_n,
  output logic               wrtrf
);
  import cga_dcd_pkg::*;

  comm_t comm;     // Registered command
  mis_t  mis;      // Registered qualifier
  logic  wrtrf_q;  // Register file write, one cycle after the word

  cga_dcd_comm_decode u_comm (
    .s_mclk (s_mclk),
    .s_mr_n (s_mr_n),
    .cscomm (cscomm),
    .csmis  (csmis),
    .lcs_n  (lcs_n),
    .comm   (comm),
    .mis    (mis),
    .ldlc_n (ldlc_n),
    .ldpil_n(ldpil_n),
    .dstop_n(dstop_n)
  );

  cga_dcd_branch u_branch (
    .comm  (comm),
    .mis   (mis),
    .cry   (cry),
    .f15   (f15),
    .sgr   (sgr),
    .zf    (zf),
    .wp_n  (wp_n),
    .cbrk_n(cbrk_n),
    .ind_n (ind_n)
  );

  cga_dcd_cs_strobes u_cs (
    .s_mclk (s_mclk),
    .s_mr_n (s_mr_n),
    .cscomm (cscomm),
    .csmis  (csmis),
    .lcs_n  (lcs_n),
    .brk_n  (brk_n),
    .write_n(write_n),
    .clff_n (clff_n),
    .clirq_n(clirq_n),
    .epic   (epic),
    .lwca_n (lwca_n),
    .ldgpr_n(ldgpr_n),
    .wrtrf  (wrtrf),
    .wrtrf_q(wrtrf_q),
    .fetch_n(fetch_n),
    .cfetch (cfetch),
    .csmreq (csmreq)
  );

  cga_dcd_idb_enables u_idb (
    .s_mclk (s_mclk),
    .s_mr_n (s_mr_n),
    .csidbs (csidbs),
    .lcs_n  (lcs_n),
    .wrtrf_q(wrtrf_q),
    .epgs_n (epgs_n),
    .epcr_n (epcr_n),
    .epicv_n(epicv_n),
    .epics_n(epics_n),
    .erf_n  (erf_n)
  );

endmodule

`default_nettype wire

// ==== cga_dcd_tb.sv ====
// Testbench for the decoder with clock, reset, LFSR stimulus, reference rules and checks
`timescale 1ns/1ps
`default_nettype none

module cga_dcd_tb;
  import cga_dcd_pkg::*;

  localparam int RESET_CYCLES  = 16;
  localparam int SWEEP_CYCLES  = 2 * 32 * 4;  // Every command and mis under two lcs_n patterns
  localparam int BRANCH_CYCLES = 8 * 4 * 4;
  localparam int RANDOM_CYCLES = 2000;
  localparam int TOTAL_CYCLES  = RESET_CYCLES + SWEEP_CYCLES + BRANCH_CYCLES +
                                 RANDOM_CYCLES + 16;
  localparam int TIMEOUT_NS    = TOTAL_CYCLES * 10 + 1000;

  logic  s_mclk;
  logic  s_mr_n;
  comm_t cscomm;
  mis_t  csmis;
  idbs_t csidbs;
  logic  lcs_n, brk_n, cry, f15, sgr, zf, wp_n;
  logic  cbrk_n, cfetch, clff_n, clirq_n, csmreq, dstop_n, epcr_n, epgs_n, epic;
  logic  epics_n, epicv_n, erf_n, fetch_n, ind_n, ldgpr_n, ldlc_n, ldpil_n;
  logic  lwca_n, write_n, wrtrf;

  int          errors;
  int          tests_run;
  int          tests_failed;
  logic [31:0] lfsr = 32'h6418_8cfb;

  // Input history one to three words back
  comm_t h1_comm, h2_comm, h3_comm;
  mis_t  h1_mis;
  idbs_t h1_idbs;
  logic  h1_lcs, h2_lcs, h3_lcs;
  logic  m_cfetch;   // Expected break-captured fetch
  comm_t reg_now;    // Command register as it should read now
  comm_t reg_stop;   // Register value that drives the stop decode
  logic [7:0] exp_cs;
  logic [4:0] exp_idb;
  logic [2:0] exp_reg;
  logic [1:0] exp_br;

  cga_dcd UUT (.*);

  initial begin
    s_mclk = 1'b0;
    forever #5 s_mclk = ~s_mclk;
  end

  // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int b = 0; b < n; b++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic comm_t reg_command(input comm_t c, input logic l);
    return {c[4] & l, c[3:0]};  // Bit 4 lost under LCS
  endfunction

  function automatic logic fetch_rule(input comm_t c, input mis_t m, input logic l);
    return l && (c == 5'o23 || c == 5'o27 || (c >= 5'o24 && c <= 5'o27) ||
                 ((c == 5'o22 || c == 5'o26) && m == 2'd3));
  endfunction

  function automatic logic csmreq_rule(input comm_t c, input mis_t m, input logic l);
    return l && ((c == 5'o22 && m != 2'd2) || c == 5'o23 || c == 5'o27 ||
                 (c >= 5'o24 && c <= 5'o27) || (c >= 5'o30 && c <= 5'o33) ||
                 c == 5'o34 || c == 5'o35);
  endfunction

  // Branch taken from registered command and qualifier with the live flags
  function automatic logic branch_rule(input comm_t c, input mis_t m,
                                       input logic cf, input logic f, input logic s,
                                       input logic z, input logic wp);
    logic [3:0] tests;
    tests = 4'b0000;
    if (c == 5'o24)
      tests = {cf, ~cf, s, ~s};
    else if (c == 5'o25 || c == 5'o23)
      tests = {z, ~z, f, ~f};
    else if (c == 5'o22)
      tests = {~wp, 3'b000};
    return tests[m];
  endfunction

  always_ff @(posedge s_mclk or negedge s_mr_n) begin
    if (!s_mr_n) begin
      {h1_comm, h2_comm, h3_comm} <= '0;
      {h1_lcs, h2_lcs, h3_lcs}    <= 3'b111;
      h1_mis   <= '0;
      h1_idbs  <= '0;
      m_cfetch <= 1'b0;
    end else begin
      {h1_comm, h2_comm, h3_comm} <= {cscomm, h1_comm, h2_comm};
      {h1_lcs, h2_lcs, h3_lcs}    <= {lcs_n, h1_lcs, h2_lcs};
      h1_mis  <= csmis;
      h1_idbs <= csidbs;
      if (!brk_n)
        m_cfetch <= fetch_rule(h1_comm, h1_mis, h1_lcs);
    end
  end

  assign reg_now  = reg_command(h1_comm, h1_lcs);
  assign reg_stop = reg_command(h3_comm, h3_lcs);

  assign exp_cs = {~(h1_lcs && (h1_comm == 5'o32 || h1_comm == 5'o33 || h1_comm == 5'o35)),
                   ~(h1_lcs && h1_comm == CMD_CLFF),
                   ~(h1_lcs && h1_comm == CMD_CLIRQ),
                   h1_lcs && h1_comm == CMD_EPIC,
                   ~(h1_lcs && h1_comm == CMD_LWCA && h1_mis == 2'd0),
                   ~(h1_lcs && (h1_comm == CMD_LDGPR ||
                                (h1_comm == 5'o22 && h1_mis == 2'd2))),
                   h1_lcs && h1_comm == CMD_WRTRF,
                   ~fetch_rule(h1_comm, h1_mis, h1_lcs)};

  assign exp_idb = {~(h1_lcs && h1_idbs == SRC_PGS), ~(h1_lcs && h1_idbs == SRC_PCR),
                    ~(h1_lcs && h1_idbs == SRC_PICV), ~(h1_lcs && h1_idbs == SRC_PICS),
                    ~((h1_lcs && h1_idbs == SRC_REG) || (h2_lcs && h2_comm == CMD_WRTRF))};

  assign exp_reg = {~(lcs_n && reg_now == CMD_LDLC), ~(lcs_n && reg_now == CMD_LDPIL),
                    ~(h2_lcs && reg_stop == CMD_DSTOP)};

  assign exp_br = {~branch_rule(reg_now, h1_mis, cry, f15, sgr, zf, wp_n),
                   ~(reg_now == 5'o22 && h1_mis <= 2'd1)};

  task automatic note_mismatch(input string what, input logic [7:0] got,
                               input logic [7:0] exp);
    errors++;
    $display("mismatch at %0t ns: %s got %b expected %b", $time, what, got, exp);
  endtask

  cs_strobes_a : assert property (@(posedge s_mclk) disable iff (!s_mr_n)
    {write_n, clff_n, clirq_n, epic, lwca_n, ldgpr_n, wrtrf, fetch_n} == exp_cs)
    else note_mismatch("live strobes", $sampled({write_n, clff_n, clirq_n, epic,
                       lwca_n, ldgpr_n, wrtrf, fetch_n}), $sampled(exp_cs));
  csmreq_a : assert property (@(posedge s_mclk) disable iff (!s_mr_n)
    csmreq == csmreq_rule(cscomm, csmis, lcs_n))
    else note_mismatch("csmreq", $sampled(csmreq), $sampled(csmreq_rule(cscomm, csmis, lcs_n)));
  idb_a : assert property (@(posedge s_mclk) disable iff (!s_mr_n)
    {epgs_n, epcr_n, epicv_n, epics_n, erf_n} == exp_idb)
    else note_mismatch("IDB enables", $sampled({epgs_n, epcr_n, epicv_n, epics_n, erf_n}),
                       $sampled(exp_idb));
  reg_strobes_a : assert property (@(posedge s_mclk) disable iff (!s_mr_n)
    {ldlc_n, ldpil_n, dstop_n} == exp_reg)
    else note_mismatch("ldlc ldpil dstop", $sampled({ldlc_n, ldpil_n, dstop_n}),
                       $sampled(exp_reg));
  branch_a : assert property (@(posedge s_mclk) disable iff (!s_mr_n)
    {cbrk_n, ind_n} == exp_br)
    else note_mismatch("cbrk_n ind_n", $sampled({cbrk_n, ind_n}), $sampled(exp_br));
  cfetch_a : assert property (@(posedge s_mclk) disable iff (!s_mr_n) cfetch == m_cfetch)
    else note_mismatch("cfetch", $sampled(cfetch), $sampled(m_cfetch));
  reset_clirq_a : assert property (@(posedge s_mclk) !s_mr_n |-> !clirq_n)
    else note_mismatch("clirq_n in reset", $sampled(clirq_n), 8'd0);
  reset_values_a : assert property (@(posedge s_mclk) $rose(s_mr_n) |->
    &{cbrk_n, clff_n, clirq_n, dstop_n, epcr_n, epgs_n, epics_n, epicv_n, erf_n,
      fetch_n, ind_n, ldgpr_n, ldlc_n, ldpil_n, lwca_n, write_n} &&
    !epic && !wrtrf && !cfetch)
    else begin
      errors++;
      $display("outputs were not at their reset values when reset was released");
    end

  task automatic drive(input comm_t c, input mis_t m, input idbs_t i, input logic l);
    logic [31:0] r;
    @(posedge s_mclk);
    #1;
    r      = take_bits(6);
    cscomm = c;
    csmis  = m;
    csidbs = i;
    lcs_n  = l;
    {brk_n, cry, f15, sgr, zf, wp_n} = r[5:0];
  endtask

  task automatic idle(input int n);
    repeat (n) drive(5'o00, 2'd0, 5'o00, 1'b1);
  endtask

  task automatic finish_test(input string name, input int err_start);
    int n;
    n = errors - err_start;
    tests_run++;
    if (n != 0)
      tests_failed++;
    $display("test %-8s %s, %0d mismatches", name, (n == 0) ? "ok" : "failed", n);
  endtask

  initial begin
    int          start;
    logic [31:0] r;
    {errors, tests_run, tests_failed} = '0;
    s_mr_n = 1'b0;
    {cscomm, csmis, csidbs} = '0;
    {lcs_n, brk_n, wp_n}    = 3'b111;
    {cry, f15, sgr, zf}     = 4'b0000;

    start = errors;
    repeat (RESET_CYCLES) @(posedge s_mclk);
    #1 s_mr_n = 1'b1;
    repeat (2) @(posedge s_mclk);
    finish_test("reset", start);

    // Every command with each mis and source and again with lcs_n low on even mis
    start = errors;
    for (int pass = 0; pass < 2; pass++)
      for (int c = 0; c < 32; c++)
        for (int m = 0; m < 4; m++)
          drive(c[4:0], m[1:0], c[4:0], (pass == 0) ? 1'b1 : m[0]);
    idle(3);
    finish_test("sweep", start);

    start = errors;
    repeat (8)
      for (int c = 5'o22; c <= 5'o25; c++)
        for (int m = 0; m < 4; m++) begin
          r = take_bits(5);
          drive(c[4:0], m[1:0], r[4:0], 1'b1);
        end
    idle(3);
    finish_test("branch", start);

    start = errors;
    repeat (RANDOM_CYCLES) begin
      r = take_bits(15);
      drive(r[14:10], r[9:8], r[7:3], |r[2:0]);  // LCS about one word in eight
    end
    idle(3);
    finish_test("random", start);

    $display("tests run %0d, tests failed %0d, mismatches %0d",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("watchdog expired after %0d ns, the tests did not finish", TIMEOUT_NS);
    $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== cga_dcd.f ====
cga_dcd_pkg.sv
cga_dcd_comm_decode.sv
cga_dcd_branch.sv
cga_dcd_cs_strobes.sv
cga_dcd_idb_enables.sv
cga_dcd.sv
cga_dcd_tb.sv

// ==== Bender.yml ====
package:
  name: cga_dcd

sources:
  - cga_dcd_pkg.sv
  - cga_dcd_comm_decode.sv
  - cga_dcd_branch.sv
  - cga_dcd_cs_strobes.sv
  - cga_dcd_idb_enables.sv
  - cga_dcd.sv
  - target: test
    files:
      - cga_dcd_tb.sv
